// ==== list.f ====
logic/recovery_pkg.sv
logic/rf_address_generator.sv
logic/rapid_recovery_ctrl.sv
logic/backup_state.sv
logic/rf_write_arbiter.sv
logic/core_regfile.sv
logic/recovery_top.sv
verif/recovery_assertions.sv
verif/recovery_tb.sv

// ==== logic/backup_state.sv ====
// ************************************************
// Shadow register file and backup PC
// Commits checked core writes one cycle late
// Supplies restore data and the recovered PC
// ************************************************

`timescale 1ns/1ps

module backup_state import recovery_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           start_recovery_i,
  input  logic           backup_enable_i,
  input  regfile_write_t core_wr_i,
  input  pc_update_t     core_pc_i,
  input  regfile_write_t rec_wr_i,
  input  logic           recover_pc_i,
  output regfile_write_t rec_wr_o,
  output pc_update_t     recovered_pc_o
);

  logic [DataWidth-1:0] shadow_q [NumRegs];
  logic [DataWidth-1:0] pc_q;

  // Writes waiting one cycle for the error check
  regfile_write_t pend_wr_q;
  pc_update_t     pend_pc_q;
  logic           commit_ok;

  // An error strobe in the check cycle discards the pending write
  // A disabled backup drops it too, so error-cycle writes never land
  assign commit_ok = backup_enable_i & ~start_recovery_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pend_wr_q <= '0;
      pend_pc_q <= '0;
    end else begin
      pend_wr_q      <= core_wr_i;
      pend_wr_q.we_a <= core_wr_i.we_a & backup_enable_i;
      pend_wr_q.we_b <= core_wr_i.we_b & backup_enable_i;
      pend_pc_q      <= core_pc_i;
      pend_pc_q.valid <= core_pc_i.valid & backup_enable_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        shadow_q[i] <= '0;
      end
      pc_q <= '0;
    end else if (commit_ok) begin
      if (pend_wr_q.we_a) begin
        shadow_q[pend_wr_q.waddr_a] <= pend_wr_q.wdata_a;
      end
      // Port b last, wins on the same address
      if (pend_wr_q.we_b) begin
        shadow_q[pend_wr_q.waddr_b] <= pend_wr_q.wdata_b;
      end
      if (pend_pc_q.valid) begin
        pc_q <= pend_pc_q.pc;
      end
    end
  end

  // Restore stream keeps strobes and addresses, data comes from the shadow
  always_comb begin
    rec_wr_o         = rec_wr_i;
    rec_wr_o.wdata_a = shadow_q[rec_wr_i.waddr_a];
    rec_wr_o.wdata_b = shadow_q[rec_wr_i.waddr_b];
  end

  assign recovered_pc_o.valid = recover_pc_i;
  assign recovered_pc_o.pc    = pc_q;

endmodule

// ==== logic/core_regfile.sv ====
// ************************************************
// Core register file
// Two write ports and one combinational read port
// ************************************************

`timescale 1ns/1ps

module core_regfile import recovery_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  regfile_write_t         rf_wr_i,
  input  logic [RFAddrWidth-1:0] raddr_i,
  output logic [DataWidth-1:0]   rdata_o
);

  logic [DataWidth-1:0] regs_q [NumRegs];

  // Per-register write enables and data
  // b is checked after a, so it overrides on a shared address
  logic [NumRegs-1:0]   wr_en;
  logic [DataWidth-1:0] wr_data [NumRegs];

  always_comb begin
    for (int i = 0; i < NumRegs; i++) begin
      wr_en[i]   = 1'b0;
      wr_data[i] = '0;
      if (rf_wr_i.we_a && (rf_wr_i.waddr_a == RFAddrWidth'(i))) begin
        wr_en[i]   = 1'b1;
        wr_data[i] = rf_wr_i.wdata_a;
      end
      if (rf_wr_i.we_b && (rf_wr_i.waddr_b == RFAddrWidth'(i))) begin
        wr_en[i]   = 1'b1;
        wr_data[i] = rf_wr_i.wdata_b;
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumRegs; i++) begin
        if (wr_en[i]) begin
          regs_q[i] <= wr_data[i];
        end
      end
    end
  end

  // Read port, no bypass from the write ports
  assign rdata_o = regs_q[raddr_i];

endmodule

// ==== logic/rapid_recovery_ctrl.sv ====
// ************************************************
// Recovery sequencer FSM
// Setback, lock, debug halt, restore and resume
// Drives the restore write addresses of both ports
// ************************************************

`timescale 1ns/1ps

module rapid_recovery_ctrl import recovery_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           start_recovery_i,
  input  logic           debug_halt_i,
  output logic           recovery_finished_o,
  // Core control
  output logic           setback_o,
  output logic           instr_lock_o,
  output logic           debug_req_o,
  output logic           debug_resume_o,
  // Backup control
  output logic           backup_enable_o,
  output regfile_write_t rec_wr_o,
  output logic           recover_pc_o
);

  typedef enum logic [1:0] {
    IDLE,
    RESET,
    HALT,
    RESTORE
  } rec_state_e;

  rec_state_e state_d, state_q;

  logic instr_lock_d, instr_lock_q;
  logic backup_en_d, backup_en_q;
  logic setback_d, setback_q;
  logic restore_en;
  logic addr_done;
  logic [HalfAddrWidth-1:0] addr_cnt;

  // One counter serves both write ports
  rf_address_generator u_addr_gen (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .enable_i (restore_en),
    .addr_o   (addr_cnt),
    .done_o   (addr_done)
  );

  // Port a restores the lower half
  assign rec_wr_o.we_a    = restore_en;
  assign rec_wr_o.waddr_a = RFAddrWidth'(addr_cnt);
  assign rec_wr_o.wdata_a = '0;
  // Port b restores the upper half
  assign rec_wr_o.we_b    = restore_en;
  assign rec_wr_o.waddr_b = RFAddrWidth'(addr_cnt) + RFAddrWidth'(HalfRegs);
  assign rec_wr_o.wdata_b = '0;

  always_comb begin
    state_d             = state_q;
    instr_lock_d        = instr_lock_q;
    backup_en_d         = backup_en_q;
    setback_d           = 1'b0;
    debug_req_o         = 1'b0;
    debug_resume_o      = 1'b0;
    recovery_finished_o = 1'b0;
    recover_pc_o        = 1'b0;
    restore_en          = 1'b0;

    case (state_q)
      IDLE: begin
        // Error strobe only counts here
        if (start_recovery_i) begin
          // Freeze the backup before the faulty state lands in it
          backup_en_d = 1'b0;
          state_d     = RESET;
        end
      end

      RESET: begin
        // Setback pulse and instruction lock after this edge
        setback_d    = 1'b1;
        instr_lock_d = 1'b1;
        state_d      = HALT;
      end

      HALT: begin
        // Hold the request until the core reports halted
        debug_req_o = 1'b1;
        if (debug_halt_i) begin
          state_d = RESTORE;
        end
      end

      RESTORE: begin
        // PC and both register halves every cycle
        recover_pc_o = 1'b1;
        restore_en   = 1'b1;
        if (addr_done) begin
          // Last restore cycle, release the core
          instr_lock_d        = 1'b0;
          backup_en_d         = 1'b1;
          debug_resume_o      = 1'b1;
          recovery_finished_o = 1'b1;
          state_d             = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      instr_lock_q <= 1'b0;
      // Backup runs from reset on
      backup_en_q  <= 1'b1;
      setback_q    <= 1'b0;
    end else begin
      state_q      <= state_d;
      instr_lock_q <= instr_lock_d;
      backup_en_q  <= backup_en_d;
      setback_q    <= setback_d;
    end
  end

  assign setback_o       = setback_q;
  assign instr_lock_o    = instr_lock_q;
  assign backup_enable_o = backup_en_q;

endmodule

// ==== logic/recovery_pkg.sv ====
// ************************************************
// Shared sizes of the rapid recovery block
// Register file write bundle and PC transfer types
// ************************************************

package recovery_pkg;

  // Architectural register count, one word each
  localparam int unsigned NumRegs = 32;

  // Register address width
  localparam int unsigned RFAddrWidth = 5;

  // Registers restored per write port
  // Port a covers the lower half, port b the upper half
  localparam int unsigned HalfRegs = NumRegs / 2;

  // Restore counter width, covers 0 to HalfRegs-1
  localparam int unsigned HalfAddrWidth = 4;

  // Register and PC width
  localparam int unsigned DataWidth = 32;

  // Two-port register file write
  // Each enable is a single-cycle strobe
  typedef struct packed {
    logic                   we_a;
    logic [RFAddrWidth-1:0] waddr_a;
    logic [DataWidth-1:0]   wdata_a;
    logic                   we_b;
    logic [RFAddrWidth-1:0] waddr_b;
    logic [DataWidth-1:0]   wdata_b;
  } regfile_write_t;

  // PC transfer
  // Used for the retiring PC of the core and for the recovered PC
  typedef struct packed {
    logic                 valid;
    logic [DataWidth-1:0] pc;
  } pc_update_t;

endpackage

// ==== logic/recovery_top.sv ====
// ************************************************
// Rapid recovery block top level
// Sequencer, backup, write arbiter and register file
// ************************************************

`timescale 1ns/1ps

module recovery_top import recovery_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_recovery_i,
  input  logic                   debug_halt_i,
  input  regfile_write_t         core_wr_i,
  input  pc_update_t             core_pc_i,
  input  logic [RFAddrWidth-1:0] raddr_i,
  output logic [DataWidth-1:0]   rdata_o,
  output logic                   setback_o,
  output logic                   instr_lock_o,
  output logic                   debug_req_o,
  output logic                   debug_resume_o,
  output logic                   recovery_finished_o,
  output pc_update_t             recovered_pc_o
);

  // Restore addresses from the sequencer, data still empty
  regfile_write_t rec_addr;
  // Restore writes with shadow data filled in
  regfile_write_t rec_wr;
  // Arbitrated writes into the register file
  regfile_write_t rf_wr;
  logic           backup_enable;
  logic           recover_pc;

  rapid_recovery_ctrl u_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .start_recovery_i    (start_recovery_i),
    .debug_halt_i        (debug_halt_i),
    .recovery_finished_o (recovery_finished_o),
    .setback_o           (setback_o),
    .instr_lock_o        (instr_lock_o),
    .debug_req_o         (debug_req_o),
    .debug_resume_o      (debug_resume_o),
    .backup_enable_o     (backup_enable),
    .rec_wr_o            (rec_addr),
    .recover_pc_o        (recover_pc)
  );

  backup_state u_backup (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .start_recovery_i (start_recovery_i),
    .backup_enable_i  (backup_enable),
    .core_wr_i        (core_wr_i),
    .core_pc_i        (core_pc_i),
    .rec_wr_i         (rec_addr),
    .recover_pc_i     (recover_pc),
    .rec_wr_o         (rec_wr),
    .recovered_pc_o   (recovered_pc_o)
  );

  rf_write_arbiter u_arbiter (
    .core_wr_i    (core_wr_i),
    .rec_wr_i     (rec_wr),
    .instr_lock_i (instr_lock_o),
    .rf_wr_o      (rf_wr)
  );

  core_regfile u_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rf_wr_i (rf_wr),
    .raddr_i (raddr_i),
    .rdata_o (rdata_o)
  );

endmodule

// ==== logic/rf_address_generator.sv ====
// ************************************************
// Restore address counter
// Steps through one half of the register file
// ************************************************

`timescale 1ns/1ps

module rf_address_generator import recovery_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     enable_i,
  output logic [HalfAddrWidth-1:0] addr_o,
  output logic                     done_o
);

  localparam logic [HalfAddrWidth-1:0] LastAddr = HalfAddrWidth'(HalfRegs - 1);

  logic [HalfAddrWidth-1:0] cnt_d, cnt_q;
  logic                     at_last;

  // Last restore address of the half
  assign at_last = (cnt_q == LastAddr);

  always_comb begin
    cnt_d = cnt_q;
    if (enable_i) begin
      // Wrap so the next recovery starts at zero again
      if (at_last) begin
        cnt_d = '0;
      end else begin
        cnt_d = cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign addr_o = cnt_q;
  // Flags the final step, only while stepping
  assign done_o = enable_i & at_last;

endmodule

// ==== logic/rf_write_arbiter.sv ====
// ************************************************
// Write port sharing for the register file
// Recovery first, core masked while locked
// ************************************************

`timescale 1ns/1ps

module rf_write_arbiter import recovery_pkg::*; (
  input  regfile_write_t core_wr_i,
  input  regfile_write_t rec_wr_i,
  input  logic           instr_lock_i,
  output regfile_write_t rf_wr_o
);

  logic core_a_ok;
  logic core_b_ok;
  regfile_write_t sel_wr;

  // Core may only use a port that recovery leaves free
  // Nothing from the core gets through while the lock is up
  assign core_a_ok = core_wr_i.we_a & ~instr_lock_i & ~rec_wr_i.we_a;
  assign core_b_ok = core_wr_i.we_b & ~instr_lock_i & ~rec_wr_i.we_b;

  always_comb begin
    sel_wr = '0;

    // Port a
    if (rec_wr_i.we_a) begin
      sel_wr.we_a    = 1'b1;
      sel_wr.waddr_a = rec_wr_i.waddr_a;
      sel_wr.wdata_a = rec_wr_i.wdata_a;
    end else if (core_a_ok) begin
      sel_wr.we_a    = 1'b1;
      sel_wr.waddr_a = core_wr_i.waddr_a;
      sel_wr.wdata_a = core_wr_i.wdata_a;
    end

    // Port b
    if (rec_wr_i.we_b) begin
      sel_wr.we_b    = 1'b1;
      sel_wr.waddr_b = rec_wr_i.waddr_b;
      sel_wr.wdata_b = rec_wr_i.wdata_b;
    end else if (core_b_ok) begin
      sel_wr.we_b    = 1'b1;
      sel_wr.waddr_b = core_wr_i.waddr_b;
      sel_wr.wdata_b = core_wr_i.wdata_b;
    end
  end

  // Same target on both ports, b wins
  always_comb begin
    rf_wr_o = sel_wr;
    if (sel_wr.we_a && sel_wr.we_b && (sel_wr.waddr_a == sel_wr.waddr_b)) begin
      rf_wr_o.we_a = 1'b0;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
verilator --binary --timing --assert --top-module recovery_tb -f list.f -o recovery_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/recovery_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "No result in log, simulation failed"; exit 1; }
echo "Simulation passed"

// ==== verif/recovery_assertions.sv ====
// **************************************************
// Concurrent checks on the recovery sequence
// and on the restore writes into the register file
// **************************************************

`timescale 1ns/1ps

module recovery_assertions import recovery_pkg::*; (
  input logic           clk_i,
  input logic           rst_ni,
  input logic           start_recovery_i,
  input logic           debug_halt_i,
  input logic           setback_i,
  input logic           instr_lock_i,
  input logic           debug_req_i,
  input logic           debug_resume_i,
  input logic           recovery_finished_i,
  input pc_update_t     recovered_pc_i,
  input regfile_write_t rec_wr_i,
  input regfile_write_t rf_wr_i
);

  // Failures so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  function automatic void note_failure(input string what);
    $error("Assertion failed: %s", what);
    fail_cnt++;
  endfunction

  // Quiet outputs in reset and on the first edge after it
  assert property (@(posedge clk_i) (!rst_ni || $rose(rst_ni)) |-> !(setback_i ||
      instr_lock_i || debug_req_i || debug_resume_i || recovery_finished_i ||
      recovered_pc_i.valid))
    else note_failure("core control active in or right after reset");

  // Setback only two edges after a start in IDLE, never from a start in RESTORE
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(setback_i) |-> $past(start_recovery_i, 2) && !$past(recovered_pc_i.valid, 2))
    else note_failure("setback without a start seen in IDLE");
  assert property (@(posedge clk_i) disable iff (!rst_ni) setback_i |=> !setback_i)
    else note_failure("setback longer than one cycle");
  assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(instr_lock_i) |-> setback_i)
    else note_failure("instruction lock rose apart from setback");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      $fell(instr_lock_i) |-> $past(recovery_finished_i))
    else note_failure("instruction lock dropped before recovery finished");

  // Debug request held until the halt arrives
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      debug_req_i && !debug_halt_i |=> debug_req_i)
    else note_failure("debug request dropped without halt");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      debug_req_i && debug_halt_i |=> !debug_req_i && recovered_pc_i.valid)
    else note_failure("restore did not follow the debug halt");

  // Exactly 16 restore cycles, finish and resume in the last one
  assert property (@(posedge clk_i) disable iff (!rst_ni) recovery_finished_i |->
      $past(recovered_pc_i.valid, 15) && !$past(recovered_pc_i.valid, 16))
    else note_failure("restore length is not 16 cycles");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      recovery_finished_i |=> !instr_lock_i && !recovered_pc_i.valid)
    else note_failure("core still locked or restoring after finish");
  assert property (@(posedge clk_i) disable iff (!rst_ni) debug_resume_i == recovery_finished_i)
    else note_failure("resume and finish not together");

  // Restore owns both ports, PC steady
  assert property (@(posedge clk_i) disable iff (!rst_ni) recovered_pc_i.valid |->
      rf_wr_i == rec_wr_i && rf_wr_i.we_a && rf_wr_i.we_b && $stable(recovered_pc_i.pc))
    else note_failure("restore write lost or recovered PC moved");
  // Locked core writes never reach the register file
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_lock_i && !recovered_pc_i.valid |-> !rf_wr_i.we_a && !rf_wr_i.we_b)
    else note_failure("register file written while the core is locked");

endmodule

// ==== verif/recovery_tb.sv ====
// **************************************************
// Testbench for the rapid recovery block
// Random core writes, recoveries with random halt
// delays, reference of the committed register values
// **************************************************

`timescale 1ns/1ps

module recovery_tb import recovery_pkg::*; ();

  localparam int unsigned Rounds      = 3;
  localparam int unsigned MaxHalt     = 7;
  // Writes, start, halt wait, restore and full readback
  localparam int unsigned RoundCycles = 8 + 2 + 3 + MaxHalt + 1 + HalfRegs + NumRegs;
  localparam int unsigned CycleLimit  = 2 * (16 + 2 * NumRegs + 8 + Rounds * RoundCycles);

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   start_recovery_i;
  logic                   debug_halt_i;
  regfile_write_t         core_wr_i;
  pc_update_t             core_pc_i;
  logic [RFAddrWidth-1:0] raddr_i;
  logic [DataWidth-1:0]   rdata_o;
  logic                   setback_o, instr_lock_o, debug_req_o;
  logic                   debug_resume_o, recovery_finished_o;
  pc_update_t             recovered_pc_o;

  // Shadow copy as the core sees it, with the one-cycle commit delay
  logic [DataWidth-1:0] ref_rf [NumRegs];
  logic [DataWidth-1:0] ref_pc;
  regfile_write_t       pend_wr;
  pc_update_t           pend_pc;
  logic                 backup_on;
  logic                 recovering;
  logic [31:0]          lfsr_q;
  int unsigned          value_errs;
  int unsigned          total_errs;
  int unsigned          cyc_cnt = 0;

  recovery_top u_recovery_top (.*);

  bind recovery_top recovery_assertions u_assertions (
    .clk_i, .rst_ni, .start_recovery_i, .debug_halt_i,
    .setback_i (setback_o), .instr_lock_i (instr_lock_o), .debug_req_i (debug_req_o),
    .debug_resume_i (debug_resume_o), .recovery_finished_i (recovery_finished_o),
    .recovered_pc_i (recovered_pc_o), .rec_wr_i (rec_wr), .rf_wr_i (rf_wr)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt == CycleLimit) begin
      $display("Timeout: run did not end within %0d cycles", CycleLimit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // One cycle of core activity, driven on the falling edge
  task automatic tick(input logic start, input logic wr, input logic halt,
                      input logic [RFAddrWidth-1:0] addr);
    regfile_write_t w;
    pc_update_t     p;
    w = '0;
    p = '0;
    if (wr) begin
      if (rand_bits(1) != 0) begin
        w.we_b    = 1'b1;
        w.waddr_b = RFAddrWidth'(rand_bits(5));
        w.wdata_b = rand_bits(32);
      end else begin
        w.we_a    = 1'b1;
        w.waddr_a = RFAddrWidth'(rand_bits(5));
        w.wdata_a = rand_bits(32);
      end
      p.valid = 1'b1;
      p.pc    = rand_bits(32) & 32'hffff_fffc;
    end
    @(negedge clk_i);
    start_recovery_i = start;
    debug_halt_i     = halt;
    core_wr_i        = w;
    core_pc_i        = p;
    raddr_i          = addr;
    // Last cycle's write lands unless the error strobe comes now
    if (backup_on && !start) begin
      if (pend_wr.we_a) ref_rf[pend_wr.waddr_a] = pend_wr.wdata_a;
      if (pend_wr.we_b) ref_rf[pend_wr.waddr_b] = pend_wr.wdata_b;
      if (pend_pc.valid) ref_pc = pend_pc.pc;
    end
    pend_wr = backup_on ? w : '0;
    pend_pc = backup_on ? p : '0;
    // A start in IDLE freezes the shadow copy
    if (start && !recovering) begin
      recovering = 1'b1;
      backup_on  = 1'b0;
    end
    #1;
  endtask

  task automatic check_regs();
    for (int i = 0; i < NumRegs; i++) begin
      tick(1'b0, 1'b0, 1'b0, RFAddrWidth'(i));
      if (rdata_o !== ref_rf[i]) begin
        $display("** Error: rdata_o[%0d] = %08h, expected %08h", i, rdata_o, ref_rf[i]);
        value_errs++;
      end
    end
  endtask

  task automatic run_recovery(input logic restart);
    int unsigned delay;
    int unsigned n;
    n = 0;
    // Corrupting write, error strobe one cycle later
    tick(1'b0, 1'b1, 1'b0, '0);
    tick(1'b1, 1'b1, 1'b0, '0);
    // Core keeps writing while set back and locked
    while (!debug_req_o) tick(1'b0, 1'b1, 1'b0, '0);
    delay = rand_bits(3);
    repeat (delay) tick(1'b0, 1'b1, 1'b0, '0);
    tick(1'b0, 1'b1, 1'b1, '0);
    do begin
      // Second start in the middle of restore
      tick(restart && (n == 5), 1'b1, 1'b0, '0);
      n++;
      if (recovered_pc_o.valid && recovered_pc_o.pc !== ref_pc) begin
        $display("** Error: recovered_pc_o.pc = %08h, expected %08h",
                 recovered_pc_o.pc, ref_pc);
        value_errs++;
      end
    end while (!recovery_finished_o);
    recovering = 1'b0;
    backup_on  = 1'b1;
  endtask

  initial begin
    rst_ni           = 1'b0;
    start_recovery_i = 1'b0;
    debug_halt_i     = 1'b0;
    core_wr_i        = '0;
    core_pc_i        = '0;
    raddr_i          = '0;
    lfsr_q           = 32'h3d3;
    value_errs       = 0;
    ref_pc           = '0;
    pend_wr          = '0;
    pend_pc          = '0;
    backup_on        = 1'b1;
    recovering       = 1'b0;
    for (int i = 0; i < NumRegs; i++) begin
      ref_rf[i] = '0;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_regs();
    for (int r = 0; r < Rounds; r++) begin
      repeat (8) tick(1'b0, 1'b1, 1'b0, '0);
      run_recovery(r == 1);
      check_regs();
    end
    // Core writes go through again after the last recovery
    repeat (8) tick(1'b0, 1'b1, 1'b0, '0);
    check_regs();
    total_errs = value_errs + u_recovery_top.u_assertions.fail_cnt;
    $display("Errors: %0d value mismatches, %0d assertion failures",
             value_errs, u_recovery_top.u_assertions.fail_cnt);
    if (total_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
